// ==== src/lsu_config.svh ====
// Load/store unit configuration macros for data width and DTIM depth
`ifndef LSU_CFG_INCLUDED
`define LSU_CFG_INCLUDED

//////////////////////////////////////////////////////////////////////
// Data path
//////////////////////////////////////////////////////////////////////

// Word width in bits
`define LSU_XLEN 32

//////////////////////////////////////////////////////////////////////
// Memory
//////////////////////////////////////////////////////////////////////

// Word address bits of the DTIM, 256 words
`define LSU_DTIM_ADR_BITS 8

`endif

// ==== src/lsu_pkg.sv ====
// Shared operation encodings, funct7 decode view and byte swap helper for the LSU
`include "lsu_config.svh"

package lsuPkg;

  // Memory operation kind, amo is read plus write
  typedef enum logic [1:0] {
    memNone  = 2'b00,
    memWrite = 2'b01,
    memRead  = 2'b10,
    memAmo   = 2'b11
  } memRwT;

  // Access size from funct3[1:0]
  typedef enum logic [1:0] {
    sizeByte = 2'b00,
    sizeHalf = 2'b01,
    sizeWord = 2'b10
  } sizeT;

  // funct5 codes of the A extension
  typedef enum logic [4:0] {
    amoAdd  = 5'b00000,
    amoSwap = 5'b00001,
    amoLr   = 5'b00010,
    amoSc   = 5'b00011,
    amoXor  = 5'b00100,
    amoOr   = 5'b01000,
    amoAnd  = 5'b01100,
    amoMin  = 5'b10000,
    amoMax  = 5'b10100,
    amoMinu = 5'b11000,
    amoMaxu = 5'b11100
  } amoOpT;

  // funct7 seen as a raw field or as funct5 plus ordering bits
  typedef union packed {
    logic [6:0] raw;
    struct packed {
      amoOpT funct5;
      logic  aq;    // Acquire
      logic  rl;    // Release
    } amo;
  } amoFunct7U;

  // Reverse byte order of a word
  function automatic logic [`LSU_XLEN-1:0] swapBytes(input logic [`LSU_XLEN-1:0] w);
    logic [`LSU_XLEN-1:0] y;
    for (int i = 0; i < `LSU_XLEN/8; i++) begin
      y[8*i +: 8] = w[`LSU_XLEN-8-8*i +: 8];
    end
    return y;
  endfunction

endpackage

// ==== src/storeFormat.sv ====
// Store formatter that replicates subword data, swaps byte order and builds byte masks
`include "lsu_config.svh"

module storeFormat (
  input  logic [2:0]              funct3M,        // Size in [1:0]
  input  logic [1:0]              adrM,           // Byte offset within the word
  input  logic                    bigEndianM,
  input  logic [`LSU_XLEN-1:0]    amoWriteDataM,  // Data after the AMO stage
  output logic [`LSU_XLEN-1:0]    storeWordM,     // Data on every lane
  output logic [`LSU_XLEN/8-1:0]  byteMaskM       // Lanes to write
);
  import lsuPkg::*;

  localparam int numLanes = `LSU_XLEN/8;

  sizeT                 sizeM;
  logic [`LSU_XLEN-1:0] replWordM;                // Replicated little-endian data
  logic [numLanes-1:0]  leMaskM;                  // Mask in little-endian lane order

  assign sizeM = sizeT'(funct3M[1:0]);

  //////////////////////////////////////////////////////////////////////
  // Data replication and swap
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (sizeM)
      sizeByte: replWordM = {numLanes{amoWriteDataM[7:0]}};       // Byte on all lanes
      sizeHalf: replWordM = {(numLanes/2){amoWriteDataM[15:0]}};  // Half on both halves
      default:  replWordM = amoWriteDataM;
    endcase
  end

  // Memory holds big-endian words byte reversed
  assign storeWordM = bigEndianM ? swapBytes(replWordM) : replWordM;

  //////////////////////////////////////////////////////////////////////
  // Byte mask
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (sizeM)
      sizeByte: leMaskM = numLanes'(1) << adrM;
      sizeHalf: leMaskM = numLanes'(2'b11) << {adrM[1], 1'b0};  // Aligned half only
      default:  leMaskM = '1;
    endcase
  end

  // Big-endian addresses land in the mirrored lanes
  always_comb begin
    for (int i = 0; i < numLanes; i++) begin
      byteMaskM[i] = bigEndianM ? leMaskM[numLanes-1-i] : leMaskM[i];
    end
  end

endmodule

// ==== src/dtim.sv ====
// Data tightly-integrated memory with byte-masked writes and a write-to-read bypass
`include "lsu_config.svh"

module dtim (
  input  logic                          clk,
  input  logic                          readEn,      // Advance the read register
  input  logic [`LSU_DTIM_ADR_BITS-1:0] readAdrE,    // Word address from E
  input  logic                          writeEn,     // Commit the M write
  input  logic [`LSU_DTIM_ADR_BITS-1:0] writeAdrM,   // Word address in M
  input  logic [`LSU_XLEN-1:0]          storeWordM,
  input  logic [`LSU_XLEN/8-1:0]        byteMaskM,
  output logic [`LSU_XLEN-1:0]          readWordM    // Registered read word
);

  localparam int numWords = 1 << `LSU_DTIM_ADR_BITS;
  localparam int numLanes = `LSU_XLEN/8;

  logic [`LSU_XLEN-1:0] mem [0:numWords-1];
  logic [`LSU_XLEN-1:0] rawWordE;                    // Array contents before this write
  logic [`LSU_XLEN-1:0] fwdWordE;                    // With same-cycle write merged in
  logic                 hitE;

  //////////////////////////////////////////////////////////////////////
  // Read with bypass
  //////////////////////////////////////////////////////////////////////

  assign rawWordE = mem[readAdrE];
  assign hitE     = writeEn & (writeAdrM == readAdrE);  // Store then load, same word

  always_comb begin
    fwdWordE = rawWordE;
    for (int i = 0; i < numLanes; i++) begin
      if (hitE & byteMaskM[i]) begin
        fwdWordE[8*i +: 8] = storeWordM[8*i +: 8];   // Newly written byte wins
      end
    end
  end

  always_ff @(posedge clk) begin
    if (readEn) begin
      readWordM <= fwdWordE;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Byte-masked write
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    for (int i = 0; i < numLanes; i++) begin
      if (writeEn & byteMaskM[i]) begin
        mem[writeAdrM][8*i +: 8] <= storeWordM[8*i +: 8];
      end
    end
  end

endmodule

// ==== src/loadFormat.sv ====
// Load formatter with endian swap, subword extraction and the M-to-W data register
`include "lsu_config.svh"

module loadFormat (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stallW,        // Hold the W register
  input  logic [`LSU_XLEN-1:0] readWordM,     // Word from the DTIM
  input  logic [2:0]           funct3M,       // Size in [1:0], unsigned in [2]
  input  logic [1:0]           adrM,          // Byte offset within the word
  input  logic                 bigEndianM,
  output logic [`LSU_XLEN-1:0] readDataM,     // Extended load data in M
  output logic [`LSU_XLEN-1:0] readDataW      // Same, one stage later
);
  import lsuPkg::*;

  sizeT                 sizeM;
  logic                 unsignedM;
  logic [`LSU_XLEN-1:0] orderedWordM;         // Word in little-endian order
  logic [7:0]           byteM;
  logic [15:0]          halfM;

  assign sizeM     = sizeT'(funct3M[1:0]);
  assign unsignedM = funct3M[2];              // lbu, lhu

  //////////////////////////////////////////////////////////////////////
  // Swap and select
  //////////////////////////////////////////////////////////////////////

  assign orderedWordM = bigEndianM ? swapBytes(readWordM) : readWordM;
  assign byteM = orderedWordM[{adrM, 3'b000} +: 8];
  assign halfM = orderedWordM[{adrM[1], 4'b0000} +: 16];  // Aligned halves only

  // Sign or zero extension
  always_comb begin
    case (sizeM)
      sizeByte: readDataM = {{(`LSU_XLEN-8){~unsignedM & byteM[7]}}, byteM};
      sizeHalf: readDataM = {{(`LSU_XLEN-16){~unsignedM & halfM[15]}}, halfM};
      default:  readDataM = orderedWordM;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // M to W register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      readDataW <= '0;
    end else if (~stallW) begin
      readDataW <= readDataM;
    end
  end

endmodule

// ==== src/atomicUnit.sv ====
// Atomic unit holding the LR/SC reservation and computing AMO store data
`include "lsu_config.svh"

module atomicUnit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stallM,         // Reservation changes only when M advances
  input  logic                 stallW,         // Hold the squash flag
  input  lsuPkg::memRwT        preRwM,         // Operation kind before SC gating
  input  lsuPkg::amoFunct7U    funct7M,
  input  logic [1:0]           atomicM,        // 10 LR/SC, 01 AMO
  input  logic [`LSU_XLEN-1:0] adrM,
  input  logic [`LSU_XLEN-1:0] readDataM,      // Old memory word
  input  logic [`LSU_XLEN-1:0] writeDataM,     // Register operand
  output lsuPkg::memRwT        lsuRwM,         // Kind sent to the memory
  output logic [`LSU_XLEN-1:0] amoWriteDataM,  // Data for the store formatter
  output logic                 squashScW       // Failed SC in W
);
  import lsuPkg::*;

  amoOpT                  funct5M;
  logic                   activeM;             // Real operation in M
  logic                   lrM;
  logic                   scM;
  logic                   scFailM;
  logic                   amoM;
  logic                   resValid;            // Reservation held
  logic [`LSU_XLEN-3:0]   resAdr;              // Reserved word address
  logic [`LSU_XLEN-1:0]   amoResultM;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  assign funct5M = funct7M.amo.funct5;
  assign activeM = (preRwM != memNone);
  assign lrM     = activeM & atomicM[1] & (funct5M == amoLr);
  assign scM     = activeM & atomicM[1] & (funct5M == amoSc);
  assign amoM    = activeM & atomicM[0];

  // SC needs a live reservation on the same word
  assign scFailM = scM & ~(resValid & (resAdr == adrM[`LSU_XLEN-1:2]));
  assign lsuRwM  = scFailM ? memNone : preRwM;  // Failed SC does not write

  //////////////////////////////////////////////////////////////////////
  // Reservation
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      resValid <= 1'b0;
    end else if (~stallM) begin
      if (lrM) begin
        resValid <= 1'b1;
      end else if (scM) begin
        resValid <= 1'b0;                      // Any SC consumes it
      end
    end
  end

  always_ff @(posedge clk) begin
    if (~stallM & lrM) begin
      resAdr <= adrM[`LSU_XLEN-1:2];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // AMO arithmetic
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (funct5M)
      amoAdd:  amoResultM = readDataM + writeDataM;
      amoXor:  amoResultM = readDataM ^ writeDataM;
      amoAnd:  amoResultM = readDataM & writeDataM;
      amoOr:   amoResultM = readDataM | writeDataM;
      amoMin:  amoResultM = ($signed(readDataM) < $signed(writeDataM)) ? readDataM : writeDataM;
      amoMax:  amoResultM = ($signed(readDataM) > $signed(writeDataM)) ? readDataM : writeDataM;
      amoMinu: amoResultM = (readDataM < writeDataM) ? readDataM : writeDataM;
      amoMaxu: amoResultM = (readDataM > writeDataM) ? readDataM : writeDataM;
      default: amoResultM = writeDataM;        // Swap
    endcase
  end

  assign amoWriteDataM = amoM ? amoResultM : writeDataM;

  // Squash travels to W with the load data
  always_ff @(posedge clk) begin
    if (rst) begin
      squashScW <= 1'b0;
    end else if (~stallW) begin
      squashScW <= scFailM;
    end
  end

endmodule

// ==== src/lsu.sv ====
// Load/store unit top with the E-to-M operation register, DTIM and data formatting
`include "lsu_config.svh"

module lsu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  stallM,      // Hold M stage
  input  logic                  stallW,      // Hold W stage
  input  logic                  flushM,      // Kill the operation entering M
  input  lsuPkg::memRwT         memRwE,      // Read, write or AMO
  input  logic [2:0]            funct3E,     // Size and unsigned bit
  input  lsuPkg::amoFunct7U     funct7E,     // AMO function
  input  logic [1:0]            atomicE,     // 10 LR/SC, 01 AMO
  input  logic [`LSU_XLEN-1:0]  ieuAdrE,     // Byte address from execute
  input  logic [`LSU_XLEN-1:0]  writeDataE,  // Store data from execute
  input  logic                  bigEndianE,
  output logic [`LSU_XLEN-1:0]  readDataW,   // Load result to writeback
  output logic                  squashScW    // Failed SC, no register write
);
  import lsuPkg::*;

  memRwT                  preRwM;            // Operation kind in M
  memRwT                  lsuRwM;            // Kind after SC gating
  logic [2:0]             funct3M;
  amoFunct7U              funct7M;
  logic [1:0]             atomicM;
  logic [`LSU_XLEN-1:0]   adrM;
  logic [`LSU_XLEN-1:0]   writeDataM;
  logic                   bigEndianM;
  logic [`LSU_XLEN-1:0]   readWordM;         // Raw DTIM word
  logic [`LSU_XLEN-1:0]   readDataM;         // Formatted load data
  logic [`LSU_XLEN-1:0]   amoWriteDataM;     // AMO result or plain store data
  logic [`LSU_XLEN-1:0]   storeWordM;        // Lane-aligned store data
  logic [`LSU_XLEN/8-1:0] byteMaskM;
  logic                   dtimWriteEnM;

  //////////////////////////////////////////////////////////////////////
  // E to M register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst | flushM) begin
      preRwM  <= memNone;                    // Bubble
      atomicM <= 2'b00;
    end else if (~stallM) begin
      preRwM  <= memRwE;
      atomicM <= atomicE;
    end
  end

  always_ff @(posedge clk) begin
    if (~stallM) begin
      funct3M     <= funct3E;
      funct7M.raw <= funct7E.raw;            // Decoded later as funct5/aq/rl
      adrM        <= ieuAdrE;
      writeDataM  <= writeDataE;
      bigEndianM  <= bigEndianE;
    end
  end

  // Writes commit only on an advancing cycle
  assign dtimWriteEnM = lsuRwM[0] & ~stallM;

  //////////////////////////////////////////////////////////////////////
  // Datapath blocks
  //////////////////////////////////////////////////////////////////////

  dtim u_dtim (
    .clk, .readEn(~stallM), .readAdrE(ieuAdrE[`LSU_DTIM_ADR_BITS+1:2]),
    .writeEn(dtimWriteEnM), .writeAdrM(adrM[`LSU_DTIM_ADR_BITS+1:2]),
    .storeWordM, .byteMaskM, .readWordM
  );

  loadFormat u_loadFormat (
    .clk, .rst, .stallW, .readWordM, .funct3M, .adrM(adrM[1:0]),
    .bigEndianM, .readDataM, .readDataW
  );

  atomicUnit u_atomicUnit (
    .clk, .rst, .stallM, .stallW, .preRwM, .funct7M, .atomicM, .adrM,
    .readDataM, .writeDataM, .lsuRwM, .amoWriteDataM, .squashScW
  );

  storeFormat u_storeFormat (
    .funct3M, .adrM(adrM[1:0]), .bigEndianM, .amoWriteDataM,
    .storeWordM, .byteMaskM
  );

endmodule

// ==== tb/lsuTable.svh ====
// Operation table for the LSU testbench with the reference memory model that fills its expectations
`ifndef LSU_TABLE_INCLUDED
`define LSU_TABLE_INCLUDED

localparam int maxOps = 48;

// One column per field, indexed by entry
memRwT       opKind  [maxOps];
logic [2:0]  opF3    [maxOps];
amoOpT       opF5    [maxOps];
logic [1:0]  opAtom  [maxOps];              // 10 LR/SC, 01 AMO
logic [31:0] opAdr   [maxOps];
logic [31:0] opData  [maxOps];
logic        opBe    [maxOps];
logic [31:0] expData [maxOps];              // Expected readDataW, loads and AMOs only
logic        expSq   [maxOps];              // Expected squashScW
int          numOps = 0;

// Model state
logic [31:0] refMem [1 << `LSU_DTIM_ADR_BITS];
logic        refResValid;
logic [29:0] refResAdr;                     // Reserved word address

//////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////

// Big-endian memory word is the byte reverse of the core's view
function automatic logic [31:0] revBytes(input logic [31:0] w);
  return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

function automatic logic [31:0] loadValue(input logic [31:0] v, input logic [2:0] f3,
                                          input logic [1:0] off);
  logic [7:0]  b;
  logic [15:0] h;
  b = v[{off, 3'b000} +: 8];
  h = v[{off[1], 4'b0000} +: 16];
  case (f3[1:0])
    2'b00:   return f3[2] ? {24'h0, b} : {{24{b[7]}}, b};     // lbu / lb
    2'b01:   return f3[2] ? {16'h0, h} : {{16{h[15]}}, h};    // lhu / lh
    default: return v;
  endcase
endfunction

// New memory word of an AMO from old word a and operand b
function automatic logic [31:0] amoValue(input amoOpT op, input logic [31:0] a,
                                         input logic [31:0] b);
  case (op)
    amoAdd:  return a + b;
    amoXor:  return a ^ b;
    amoAnd:  return a & b;
    amoOr:   return a | b;
    amoMin:  return ($signed(a) < $signed(b)) ? a : b;
    amoMax:  return ($signed(a) < $signed(b)) ? b : a;
    amoMinu: return (a < b) ? a : b;
    amoMaxu: return (a < b) ? b : a;
    default: return b;                      // Swap
  endcase
endfunction

// Append an entry and run it through the model
task automatic addOp(input memRwT kind, input logic [2:0] f3, input amoOpT f5,
                     input logic [1:0] at, input logic [31:0] adr,
                     input logic [31:0] data, input logic be);
  logic [`LSU_DTIM_ADR_BITS-1:0] wa;
  logic [31:0]                   view;
  logic [31:0]                   wdata;
  logic                          doWrite;
  wa   = adr[`LSU_DTIM_ADR_BITS+1:2];
  view = be ? revBytes(refMem[wa]) : refMem[wa];
  opKind[numOps]  = kind;
  opF3[numOps]    = f3;
  opF5[numOps]    = f5;
  opAtom[numOps]  = at;
  opAdr[numOps]   = adr;
  opData[numOps]  = data;
  opBe[numOps]    = be;
  expData[numOps] = loadValue(view, f3, adr[1:0]);  // AMO returns the old word
  expSq[numOps]   = 1'b0;
  doWrite = (kind == memWrite) || (kind == memAmo);
  if (at == 2'b10 && f5 == amoLr) begin
    refResValid = 1'b1;
    refResAdr   = adr[31:2];
  end else if (at == 2'b10 && f5 == amoSc) begin
    expSq[numOps] = ~(refResValid & (refResAdr == adr[31:2]));
    doWrite       = ~expSq[numOps];          // Failed SC leaves memory alone
    refResValid   = 1'b0;
  end
  if (doWrite) begin
    wdata = (kind == memAmo) ? amoValue(f5, view, data) : data;
    case (f3[1:0])
      2'b00:   view[{adr[1:0], 3'b000} +: 8] = wdata[7:0];
      2'b01:   view[{adr[1], 4'b0000} +: 16] = wdata[15:0];
      default: view = wdata;
    endcase
    refMem[wa] = be ? revBytes(view) : view;
  end
  numOps++;
endtask

//////////////////////////////////////////////////////////////////////
// Table, funct3 010 word, 001 half, 000 byte, 1xx unsigned
//////////////////////////////////////////////////////////////////////

task automatic buildTable();
  refResValid = 1'b0;
  // kind     f3      f5       at     adr     data          be
  addOp(memWrite, 3'b010, amoAdd,  2'b00, 32'h10, 32'h11223344, 1'b0);
  addOp(memRead,  3'b010, amoAdd,  2'b00, 32'h10, '0,           1'b0);  // Bypass
  addOp(memWrite, 3'b000, amoAdd,  2'b00, 32'h11, 32'h000000f5, 1'b0);
  addOp(memRead,  3'b000, amoAdd,  2'b00, 32'h11, '0,           1'b0);
  addOp(memRead,  3'b100, amoAdd,  2'b00, 32'h11, '0,           1'b0);
  addOp(memRead,  3'b000, amoAdd,  2'b00, 32'h10, '0,           1'b0);
  addOp(memRead,  3'b000, amoAdd,  2'b00, 32'h12, '0,           1'b0);
  addOp(memRead,  3'b100, amoAdd,  2'b00, 32'h13, '0,           1'b0);
  addOp(memWrite, 3'b001, amoAdd,  2'b00, 32'h12, 32'h00008001, 1'b0);
  addOp(memRead,  3'b001, amoAdd,  2'b00, 32'h12, '0,           1'b0);
  addOp(memRead,  3'b101, amoAdd,  2'b00, 32'h12, '0,           1'b0);
  addOp(memRead,  3'b001, amoAdd,  2'b00, 32'h10, '0,           1'b0);
  addOp(memRead,  3'b010, amoAdd,  2'b00, 32'h10, '0,           1'b0);  // Unmasked bytes kept
  // Big-endian
  addOp(memWrite, 3'b010, amoAdd,  2'b00, 32'h20, 32'ha1b2c3d4, 1'b0);
  addOp(memRead,  3'b010, amoAdd,  2'b00, 32'h20, '0,           1'b1);
  addOp(memWrite, 3'b000, amoAdd,  2'b00, 32'h21, 32'h0000005e, 1'b1);
  addOp(memRead,  3'b010, amoAdd,  2'b00, 32'h20, '0,           1'b0);  // Mirrored lane
  addOp(memRead,  3'b100, amoAdd,  2'b00, 32'h21, '0,           1'b1);
  addOp(memRead,  3'b001, amoAdd,  2'b00, 32'h22, '0,           1'b1);
  // AMOs, each returns the old word
  addOp(memWrite, 3'b010, amoAdd,  2'b00, 32'h30, 32'h00000010, 1'b0);
  addOp(memAmo,   3'b010, amoAdd,  2'b01, 32'h30, 32'h00000005, 1'b0);
  addOp(memAmo,   3'b010, amoSwap, 2'b01, 32'h30, 32'hfffffff0, 1'b0);
  addOp(memAmo,   3'b010, amoMin,  2'b01, 32'h30, 32'h00000003, 1'b0);
  addOp(memAmo,   3'b010, amoMinu, 2'b01, 32'h30, 32'h00000003, 1'b0);
  addOp(memAmo,   3'b010, amoMax,  2'b01, 32'h30, 32'hffffff00, 1'b0);
  addOp(memAmo,   3'b010, amoMaxu, 2'b01, 32'h30, 32'hffffff00, 1'b0);
  addOp(memAmo,   3'b010, amoXor,  2'b01, 32'h30, 32'h0f0f0f0f, 1'b0);
  addOp(memAmo,   3'b010, amoAnd,  2'b01, 32'h30, 32'hff00ff00, 1'b0);
  addOp(memAmo,   3'b010, amoOr,   2'b01, 32'h30, 32'h00000abc, 1'b0);
  addOp(memRead,  3'b010, amoAdd,  2'b00, 32'h30, '0,           1'b0);
  // LR/SC
  addOp(memWrite, 3'b010, amoAdd,  2'b00, 32'h40, 32'h00001234, 1'b0);
  addOp(memWrite, 3'b010, amoAdd,  2'b00, 32'h44, 32'h00000055, 1'b0);
  addOp(memRead,  3'b010, amoLr,   2'b10, 32'h40, '0,           1'b0);
  addOp(memWrite, 3'b010, amoSc,   2'b10, 32'h40, 32'h0000beef, 1'b0);
  addOp(memRead,  3'b010, amoAdd,  2'b00, 32'h40, '0,           1'b0);
  addOp(memWrite, 3'b010, amoSc,   2'b10, 32'h40, 32'h0000dead, 1'b0);  // Reservation gone
  addOp(memRead,  3'b010, amoAdd,  2'b00, 32'h40, '0,           1'b0);
  addOp(memRead,  3'b010, amoLr,   2'b10, 32'h40, '0,           1'b0);
  addOp(memWrite, 3'b010, amoSc,   2'b10, 32'h44, 32'h00000077, 1'b0);  // Other word
  addOp(memRead,  3'b010, amoAdd,  2'b00, 32'h44, '0,           1'b0);
endtask

`endif

// ==== tb/lsuTb.sv ====
// Testbench for the load/store unit that runs the operation table without and with random stalls
`include "lsu_config.svh"

module lsuTb;
  timeunit 1ns;
  timeprecision 1ps;
  import lsuPkg::*;

  localparam int resetCycles = 16;

  logic                 clk;
  logic                 rst;
  logic                 stallM;
  logic                 stallW;
  logic                 flushM;
  memRwT                memRwE;
  logic [2:0]           funct3E;
  amoFunct7U            funct7E;
  logic [1:0]           atomicE;
  logic [`LSU_XLEN-1:0] ieuAdrE;
  logic [`LSU_XLEN-1:0] writeDataE;
  logic                 bigEndianE;
  logic [`LSU_XLEN-1:0] readDataW;
  logic                 squashScW;

  logic [31:0] lfsr;                        // Stall bit source
  int          passIdx;
  int          okCount;
  int          failCount;

  `include "lsuTable.svh"

  initial clk = 1'b0;
  always #50 clk = ~clk;                    // 100 ns period

  lsu u_dut (
    .clk, .rst, .stallM, .stallW, .flushM, .memRwE, .funct3E, .funct7E, .atomicE,
    .ieuAdrE, .writeDataE, .bigEndianE, .readDataW, .squashScW
  );

  ////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////

  // Galois step with taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // Present entry i in E or a bubble for i < 0
  task automatic driveOp(input int i);
    if (i < 0) begin
      memRwE <= memNone;
    end else begin
      memRwE      <= opKind[i];
      funct3E     <= opF3[i];
      funct7E.raw <= {opF5[i], 2'b00};      // aq and rl clear
      atomicE     <= opAtom[i];
      ieuAdrE     <= opAdr[i];
      writeDataE  <= opData[i];
      bigEndianE  <= opBe[i];
    end
  endtask

  // Compare the W outputs with the model result of entry i
  task automatic compareW(input int i, output logic ok);
    ok = 1'b1;
    if (opKind[i] == memRead || opKind[i] == memAmo) begin
      assert (readDataW === expData[i]) else begin
        $display("CHECK FAILED readDataW got %h expected %h (op %0d)", readDataW, expData[i], i);
        ok = 1'b0;
      end
    end
    assert (squashScW === expSq[i]) else begin
      $display("CHECK FAILED squashScW got %h expected %h (op %0d)", squashScW, expSq[i], i);
      ok = 1'b0;
    end
    if (ok) begin
      okCount++;
    end else begin
      failCount++;
    end
  endtask

  // Check a finished entry and report it
  task automatic checkOp(input int i);
    logic ok;
    compareW(i, ok);
    $display("pass %0d op %0d %s at %h: %s", passIdx, i, opKind[i].name(), opAdr[i],
             ok ? "ok" : "mismatch");
  endtask

  // Reset and then stream the table through E and check each entry as it reaches W
  task automatic runPass(input logic useStalls);
    int   issued;
    int   checked;
    int   eIdx;
    int   mIdx;
    int   wIdx;
    int   shownIdx;
    logic heldW;
    logic sm;
    logic sw;
    logic ok;
    issued   = 0;
    checked  = 0;
    eIdx     = -1;
    mIdx     = -1;
    shownIdx = -1;
    rst    <= 1'b1;
    stallM <= 1'b0;
    stallW <= 1'b0;
    driveOp(-1);
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b0;
    while (checked < numOps) begin
      @(posedge clk);
      wIdx  = -1;
      heldW = stallW;                       // W keeps its entry across this edge
      if (!stallM) begin                    // Advancing edge moves E to M and M to W
        wIdx     = mIdx;
        shownIdx = mIdx;
        mIdx     = eIdx;
        eIdx     = (issued < numOps) ? issued : -1;
        driveOp(eIdx);
        if (eIdx >= 0) begin
          issued++;
        end
      end else if (!stallW) begin
        shownIdx = mIdx;                    // W recaptures the entry held in M
      end
      sm = 1'b0;
      sw = 1'b0;
      if (useStalls) begin
        sm   = lfsr[0];
        lfsr = lfsrNext(lfsr);
        sw   = sm & lfsr[0];                // W stalls only under an M stall
        lfsr = lfsrNext(lfsr);
      end
      stallM <= sm;
      stallW <= sw;
      @(negedge clk);                       // Outputs settled
      if (wIdx >= 0) begin
        checkOp(wIdx);
        checked++;
      end else if (heldW && shownIdx >= 0) begin
        compareW(shownIdx, ok);             // Held result must not change
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////

  initial begin
    lfsr       = 32'h73981bcf;
    okCount    = 0;
    failCount  = 0;
    rst        = 1'b1;
    stallM     = 1'b0;
    stallW     = 1'b0;
    flushM     = 1'b0;
    memRwE     = memNone;
    funct3E    = '0;
    funct7E    = '0;
    atomicE    = '0;
    ieuAdrE    = '0;
    writeDataE = '0;
    bigEndianE = 1'b0;
    buildTable();
    passIdx = 0;
    runPass(1'b0);                          // Reference run without stalls
    passIdx = 1;
    runPass(1'b1);                          // Same table under random stalls
    $display("Totals: %0d checks ok, %0d checks failed", okCount, failCount);
    if (failCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Two passes of at most 4 cycles per entry plus reset
  initial begin
    wait (numOps > 0);
    repeat (2 * (4 * numOps + resetCycles)) @(posedge clk);
    $display("Timeout: the operation table did not finish in the expected number of cycles");
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+src
+incdir+tb
src/lsu_pkg.sv
src/storeFormat.sv
src/dtim.sv
src/loadFormat.sv
src/atomicUnit.sv
src/lsu.sv
tb/lsuTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module lsuTb -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/VlsuTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1
